// File: list.f
+incdir+include
src/engine_packet_pkg.sv
src/fifo_state_pkg.sv
src/sync_fifo.sv
src/hyper_pipeline.sv
src/engine_flow_ctrl.sv
src/engine_pipeline.sv
verification/engine_pipeline_sva.sv
verification/engine_pipeline_tb.sv

// File: verification/engine_pipeline_tb.sv
/*
 * Engine pipeline testbench
 * Table-driven packets with egress stalls and an ingress hold,
 * in-order payload checks, setup/done checks and a watchdog
 */

`include "engine_params.svh"

module engine_pipeline_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_ENTRIES    = 24;
    localparam int MAX_STALL      = 30;
    localparam int HOLD_IDX       = 14;
    localparam int SETUP_LIMIT    = 10;
    localparam int TIMEOUT_CYCLES = NUM_ENTRIES * (`ENGINE_PIPELINE_STAGES + MAX_STALL + 40);

    typedef struct packed {
        logic [`ENGINE_SEQ_WIDTH-1:0]    seq;
        logic [`ENGINE_VERTEX_WIDTH-1:0] vertex;
        logic [`ENGINE_DATA_WIDTH-1:0]   data;
        // Downstream stall in cycles
        logic [7:0]                      stall;
    } entry_t;

    localparam entry_t STIM_TABLE [NUM_ENTRIES] = '{
        '{16'h0000, 16'h0011, 32'h0000_0001, 8'd0},  '{16'h0001, 16'h0012, 32'hdead_beef, 8'd0},
        '{16'h0002, 16'h0a13, 32'h1234_5678, 8'd0},  '{16'h0003, 16'h0b14, 32'hffff_0000, 8'd30},
        '{16'h0004, 16'h0015, 32'h0f0f_0f0f, 8'd0},  '{16'h0005, 16'h1016, 32'h8000_0001, 8'd0},
        '{16'h0006, 16'h2017, 32'h5555_aaaa, 8'd0},  '{16'h0007, 16'h3018, 32'h0000_ffff, 8'd0},
        '{16'h0008, 16'h4019, 32'hcafe_f00d, 8'd0},  '{16'h0009, 16'h501a, 32'h7654_3210, 8'd12},
        '{16'h000a, 16'h601b, 32'h0bad_c0de, 8'd0},  '{16'h000b, 16'h701c, 32'h1111_2222, 8'd0},
        '{16'h000c, 16'h801d, 32'h3333_4444, 8'd0},  '{16'h000d, 16'h901e, 32'h5a5a_5a5a, 8'd0},
        '{16'h000e, 16'ha01f, 32'ha5a5_a5a5, 8'd0},  '{16'h000f, 16'hb020, 32'h0102_0304, 8'd0},
        '{16'h0010, 16'hc021, 32'h0506_0708, 8'd0},  '{16'h0011, 16'hd022, 32'h090a_0b0c, 8'd0},
        '{16'h0012, 16'he023, 32'hfeed_face, 8'd0},  '{16'h0013, 16'hf024, 32'h0000_0000, 8'd0},
        '{16'h0014, 16'hffff, 32'hffff_ffff, 8'd0},  '{16'h0015, 16'h0026, 32'h1357_9bdf, 8'd0},
        '{16'h0016, 16'h0027, 32'h2468_ace0, 8'd0},  '{16'h0017, 16'h0028, 32'h8421_8421, 8'd0}
    };

    logic                              ap_clk;
    logic                              areset_template_engine;
    engine_packet_pkg::engine_packet_t response_engine_in;
    engine_packet_pkg::engine_packet_t request_engine_out;
    fifo_state_pkg::fifo_ctrl_t        up_ctrl;
    fifo_state_pkg::fifo_ctrl_t        down_ctrl;
    fifo_state_pkg::fifo_status_t      up_status;
    fifo_state_pkg::fifo_status_t      down_status;
    logic                              fifo_setup_signal;
    logic                              done_out;

    int     accepted;
    int     accepted_d1;
    int     accepted_d2;
    int     received;
    int     stall_left;
    int     hold_base;
    int     gap;
    logic   hold_active;
    logic   egress_full_seen;
    logic   ingress_full_seen;
    integer seed;

    engine_pipeline dut0 (
        .ap_clk                             (ap_clk),
        .areset_template_engine             (areset_template_engine),
        .response_engine_in                 (response_engine_in),
        .fifo_response_engine_in_signals_in (up_ctrl),
        .fifo_response_engine_in_signals_out(up_status),
        .request_engine_out                 (request_engine_out),
        .fifo_request_engine_out_signals_in (down_ctrl),
        .fifo_request_engine_out_signals_out(down_status),
        .fifo_setup_signal                  (fifo_setup_signal),
        .done_out                           (done_out)
    );

    initial begin
        ap_clk = 1'b0;
        forever #10 ap_clk = ~ap_clk;
    end

    // ------------------------------
    // Helpers
    // ------------------------------
    task automatic stop_run();
        $display("TEST FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string msg);
        if (actual !== expected) begin
            $display("FAIL %0t ns: %s (got %h, expected %h)", $time, msg, actual, expected);
            stop_run();
        end
    endtask

    // Pass-through rule: payload leaves exactly as it entered
    function automatic engine_packet_pkg::engine_payload_t payload_of(input entry_t e);
        engine_packet_pkg::engine_payload_t p;
        p.seq    = e.seq;
        p.vertex = e.vertex;
        p.data   = e.data;
        return p;
    endfunction

    // One clock, then stall countdown and ingress hold release
    task automatic advance_cycle();
        @(posedge ap_clk);
        #2;
        if (stall_left > 0) begin
            stall_left--;
            if (stall_left == 0) begin
                down_ctrl.rd_en = 1'b1;
            end
        end
        if (hold_active && up_status.prog_full) begin
            ingress_full_seen = 1'b1;
            hold_active       = 1'b0;
            up_ctrl.rd_en     = 1'b1;
        end
    endtask

    task automatic wait_done();
        while (!done_out) begin
            advance_cycle();
        end
    endtask

    // ------------------------------
    // Monitor
    // ------------------------------
    always @(negedge ap_clk) begin
        if (!areset_template_engine) begin
            if (request_engine_out.valid) begin
                check_value(received < NUM_ENTRIES, 1'b1, "packet beyond end of table");
                check_value(request_engine_out.payload, payload_of(STIM_TABLE[received]),
                            $sformatf("payload of packet %0d", received));
                received++;
            end
            if (down_status.prog_full) begin
                egress_full_seen = 1'b1;
            end
            if (hold_active) begin
                check_value(received, hold_base, "packet left while ingress reads held");
            end
            // Two cycles from presentation until done_out can react
            if (accepted_d2 > received) begin
                check_value(done_out, 1'b0, "done_out high with packets outstanding");
            end
            accepted_d2 = accepted_d1;
            accepted_d1 = accepted;
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge ap_clk);
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        stop_run();
    end

    // ------------------------------
    // Stimulus
    // ------------------------------
    initial begin
        seed                   = 32'h9d717db1;
        areset_template_engine = 1'b1;
        response_engine_in     = '0;
        up_ctrl.rd_en          = 1'b1;
        down_ctrl.rd_en        = 1'b1;
        accepted               = 0;
        accepted_d1            = 0;
        accepted_d2            = 0;
        received               = 0;
        stall_left             = 0;
        hold_base              = 0;
        hold_active            = 1'b0;
        egress_full_seen       = 1'b0;
        ingress_full_seen      = 1'b0;
        repeat (8) @(posedge ap_clk);
        #2;
        areset_template_engine = 1'b0;
        check_value(request_engine_out.valid, 1'b0, "request valid after reset");
        check_value(done_out, 1'b0, "done_out after reset");
        check_value(fifo_setup_signal, 1'b1, "setup flag after reset");

        for (int n = 0; n < SETUP_LIMIT && fifo_setup_signal; n++) begin
            advance_cycle();
        end
        if (fifo_setup_signal) begin
            $display("Setup flag still high %0d cycles after reset", SETUP_LIMIT);
            stop_run();
        end
        wait_done();
        check_value(up_status.empty, 1'b1, "ingress status empty when idle");
        check_value(down_status.empty, 1'b1, "egress status empty when idle");

        for (int i = 0; i < NUM_ENTRIES; i++) begin
            // Drain, then stop ingress reads so the ingress FIFO fills
            if (i == HOLD_IDX) begin
                wait_done();
                hold_base     = accepted;
                up_ctrl.rd_en = 1'b0;
                hold_active   = 1'b1;
            end
            while (up_status.prog_full) begin
                advance_cycle();
            end
            if (STIM_TABLE[i].stall != 0) begin
                stall_left      = STIM_TABLE[i].stall;
                down_ctrl.rd_en = 1'b0;
            end
            response_engine_in.valid   = 1'b1;
            response_engine_in.payload = payload_of(STIM_TABLE[i]);
            accepted++;
            advance_cycle();
            response_engine_in.valid = 1'b0;
            if (stall_left == 0 && !hold_active) begin
                gap = $random(seed) & 3;
                repeat (gap) advance_cycle();
            end
        end

        while (received < NUM_ENTRIES || !done_out) begin
            advance_cycle();
        end
        check_value(up_status.empty, 1'b1, "ingress status empty at end");
        check_value(down_status.empty, 1'b1, "egress status empty at end");
        check_value(egress_full_seen, 1'b1, "egress prog_full seen during stall");
        check_value(ingress_full_seen, 1'b1, "ingress prog_full seen during hold");
        $display("TEST PASS");
        $finish;
    end

endmodule : engine_pipeline_tb

// File: verification/engine_pipeline_sva.sv
/*
 * Engine pipeline assertions
 * Reset and setup quiet outputs, no push into a full queue,
 * done only with both queues reported empty
 */

module engine_pipeline_sva (
    input logic                         ap_clk,
    input logic                         areset_template_engine,
    input logic                         request_valid,
    input logic                         done_out,
    input logic                         fifo_setup_signal,
    input fifo_state_pkg::fifo_status_t ingress_status,
    input fifo_state_pkg::fifo_status_t egress_status,
    input logic                         ingress_wr_en,
    input logic                         ingress_full,
    input logic                         ingress_empty,
    input logic                         egress_wr_en,
    input logic                         egress_full,
    input logic                         egress_empty
);

    timeunit 1ns;
    timeprecision 1ps;

    // Output registers are cleared by the reset edge
    reset_quiet: assert property (@(posedge ap_clk)
        areset_template_engine |=> (!request_valid && !done_out))
        else $error("request valid or done_out high after a reset cycle");

    // ------------------------------
    // Queue overflow
    // ------------------------------
    ingress_no_overflow: assert property (@(posedge ap_clk) disable iff (areset_template_engine)
        ingress_wr_en |-> !ingress_full)
        else $error("write into full ingress FIFO");

    egress_no_overflow: assert property (@(posedge ap_clk) disable iff (areset_template_engine)
        egress_wr_en |-> !egress_full)
        else $error("write into full egress FIFO");

    // Nothing still in flight may land in a queue once done is up
    done_means_empty: assert property (@(posedge ap_clk) disable iff (areset_template_engine)
        done_out |-> (ingress_status.empty && egress_status.empty
                      && ingress_empty && egress_empty))
        else $error("done_out high while a FIFO holds data");

    setup_quiet: assert property (@(posedge ap_clk) disable iff (areset_template_engine)
        fifo_setup_signal |-> !request_valid)
        else $error("request valid during FIFO setup");

endmodule : engine_pipeline_sva

bind engine_pipeline engine_pipeline_sva u_sva (
    .ap_clk                (ap_clk),
    .areset_template_engine(areset_template_engine),
    .request_valid         (request_engine_out.valid),
    .done_out              (done_out),
    .fifo_setup_signal     (fifo_setup_signal),
    .ingress_status        (fifo_response_engine_in_signals_out),
    .egress_status         (fifo_request_engine_out_signals_out),
    .ingress_wr_en         (ingress_push.valid),
    .ingress_full          (ingress_state.full),
    .ingress_empty         (ingress_state.empty),
    .egress_wr_en          (pipe_out.valid),
    .egress_full           (egress_state.full),
    .egress_empty          (egress_state.empty)
);

// File: src/engine_pipeline.sv
/*
 * Engine pipeline stage
 * Input register, ingress FIFO, processing chain, egress FIFO
 * and output register, with back-pressure and setup/done flags
 */

`include "engine_params.svh"

module engine_pipeline (
    input  logic                              ap_clk,
    input  logic                              areset_template_engine,
    input  engine_packet_pkg::engine_packet_t response_engine_in,
    input  fifo_state_pkg::fifo_ctrl_t        fifo_response_engine_in_signals_in,
    output fifo_state_pkg::fifo_status_t      fifo_response_engine_in_signals_out,
    output engine_packet_pkg::engine_packet_t request_engine_out,
    input  fifo_state_pkg::fifo_ctrl_t        fifo_request_engine_out_signals_in,
    output fifo_state_pkg::fifo_status_t      fifo_request_engine_out_signals_out,
    output logic                              fifo_setup_signal,
    output logic                              done_out
);

    localparam int PAYLOAD_W = $bits(engine_packet_pkg::engine_payload_t);

    engine_packet_pkg::engine_packet_t  ingress_push;
    engine_packet_pkg::engine_payload_t ingress_dout;
    engine_packet_pkg::engine_payload_t egress_dout;
    engine_packet_pkg::engine_packet_t  pipe_in;
    engine_packet_pkg::engine_packet_t  pipe_out;
    fifo_state_pkg::fifo_state_t        ingress_state;
    fifo_state_pkg::fifo_state_t        egress_state;
    logic                               ingress_rd_en;
    logic                               egress_rd_en;
    logic                               pipeline_busy;

    // ------------------------------
    // Flow control
    // ------------------------------
    engine_flow_ctrl u_flow (
        .ap_clk                (ap_clk),
        .areset_template_engine(areset_template_engine),
        .response_engine_in    (response_engine_in),
        .ingress_ctrl          (fifo_response_engine_in_signals_in),
        .egress_ctrl           (fifo_request_engine_out_signals_in),
        .ingress_state         (ingress_state),
        .egress_state          (egress_state),
        .egress_dout           (egress_dout),
        .pipeline_busy         (pipeline_busy),
        .ingress_push          (ingress_push),
        .ingress_rd_en         (ingress_rd_en),
        .egress_rd_en          (egress_rd_en),
        .request_engine_out    (request_engine_out),
        .ingress_status        (fifo_response_engine_in_signals_out),
        .egress_status         (fifo_request_engine_out_signals_out),
        .fifo_setup_signal     (fifo_setup_signal),
        .done_out              (done_out)
    );

    // ------------------------------
    // Ingress queue
    // ------------------------------
    sync_fifo #(
        .DEPTH      (`ENGINE_FIFO_DEPTH),
        .WIDTH      (PAYLOAD_W),
        .PROG_THRESH(`ENGINE_PROG_THRESH)
    ) u_ingress_fifo (
        .ap_clk                (ap_clk),
        .areset_template_engine(areset_template_engine),
        .din                   (ingress_push.payload),
        .wr_en                 (ingress_push.valid),
        .rd_en                 (ingress_rd_en),
        .dout                  (ingress_dout),
        .state                 (ingress_state)
    );

    // Popped entry enters the processing chain
    assign pipe_in.valid   = ingress_state.valid;
    assign pipe_in.payload = ingress_dout;

    hyper_pipeline #(
        .STAGES(`ENGINE_PIPELINE_STAGES)
    ) u_pipeline (
        .ap_clk                (ap_clk),
        .areset_template_engine(areset_template_engine),
        .din                   (pipe_in),
        .dout                  (pipe_out),
        .busy                  (pipeline_busy)
    );

    // ------------------------------
    // Egress queue
    // ------------------------------
    sync_fifo #(
        .DEPTH      (`ENGINE_FIFO_DEPTH),
        .WIDTH      (PAYLOAD_W),
        .PROG_THRESH(`ENGINE_PROG_THRESH)
    ) u_egress_fifo (
        .ap_clk                (ap_clk),
        .areset_template_engine(areset_template_engine),
        .din                   (pipe_out.payload),
        .wr_en                 (pipe_out.valid),
        .rd_en                 (egress_rd_en),
        .dout                  (egress_dout),
        .state                 (egress_state)
    );

endmodule : engine_pipeline

// File: src/engine_flow_ctrl.sv
/*
 * Engine flow control
 * Input and output register stages, pop gating with egress
 * back-pressure, neighbour status, setup and done flags
 */

module engine_flow_ctrl (
    input  logic                               ap_clk,
    input  logic                               areset_template_engine,
    input  engine_packet_pkg::engine_packet_t  response_engine_in,
    input  fifo_state_pkg::fifo_ctrl_t         ingress_ctrl,
    input  fifo_state_pkg::fifo_ctrl_t         egress_ctrl,
    input  fifo_state_pkg::fifo_state_t        ingress_state,
    input  fifo_state_pkg::fifo_state_t        egress_state,
    input  engine_packet_pkg::engine_payload_t egress_dout,
    input  logic                               pipeline_busy,
    output engine_packet_pkg::engine_packet_t  ingress_push,
    output logic                               ingress_rd_en,
    output logic                               egress_rd_en,
    output engine_packet_pkg::engine_packet_t  request_engine_out,
    output fifo_state_pkg::fifo_status_t       ingress_status,
    output fifo_state_pkg::fifo_status_t       egress_status,
    output logic                               fifo_setup_signal,
    output logic                               done_out
);

    fifo_state_pkg::fifo_ctrl_t ingress_ctrl_reg;
    fifo_state_pkg::fifo_ctrl_t egress_ctrl_reg;
    logic                       all_idle;

    // ------------------------------
    // Input capture
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_template_engine) begin
            ingress_push.valid <= 1'b0;
            ingress_ctrl_reg   <= '0;
            egress_ctrl_reg    <= '0;
        end else begin
            ingress_push.valid <= response_engine_in.valid;
            ingress_ctrl_reg   <= ingress_ctrl;
            egress_ctrl_reg    <= egress_ctrl;
        end
    end

    always_ff @(posedge ap_clk) begin
        ingress_push.payload <= response_engine_in.payload;
    end

    // ------------------------------
    // Pop gating
    // ------------------------------
    // Ingress pops hold off while the egress queue is filling up
    assign ingress_rd_en = ingress_ctrl_reg.rd_en & ~ingress_state.empty
                         & ~egress_state.prog_full;
    assign egress_rd_en  = egress_ctrl_reg.rd_en & ~egress_state.empty;

    // Nothing stored, nothing in flight, both queues out of reset
    assign all_idle = ingress_state.empty & egress_state.empty & ~pipeline_busy
                    & ~ingress_push.valid & ~ingress_state.valid
                    & ~egress_state.valid & ~request_engine_out.valid
                    & ~ingress_state.rst_busy & ~egress_state.rst_busy;

    // ------------------------------
    // Output stage
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_template_engine) begin
            request_engine_out.valid <= 1'b0;
            ingress_status           <= '{empty: 1'b1, prog_full: 1'b0};
            egress_status            <= '{empty: 1'b1, prog_full: 1'b0};
            fifo_setup_signal        <= 1'b1;
            done_out                 <= 1'b0;
        end else begin
            request_engine_out.valid <= egress_state.valid;
            ingress_status.empty     <= ingress_state.empty;
            ingress_status.prog_full <= ingress_state.prog_full;
            egress_status.empty      <= egress_state.empty;
            egress_status.prog_full  <= egress_state.prog_full;
            fifo_setup_signal        <= ingress_state.rst_busy | egress_state.rst_busy;
            done_out                 <= all_idle;
        end
    end

    // Payload follows the egress read data
    always_ff @(posedge ap_clk) begin
        request_engine_out.payload <= egress_dout;
    end

endmodule : engine_flow_ctrl

// File: src/hyper_pipeline.sv
/*
 * Processing register chain
 * Carries engine packets unchanged through STAGES registers
 * and flags when any stage still holds a packet
 */

module hyper_pipeline #(
    parameter int STAGES = 2
) (
    input  logic                           ap_clk,
    input  logic                           areset_template_engine,
    input  engine_packet_pkg::engine_packet_t din,
    output engine_packet_pkg::engine_packet_t dout,
    output logic                           busy
);

    engine_packet_pkg::engine_packet_t stage [STAGES];

    // ------------------------------
    // Valid chain
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_template_engine) begin
            for (int i = 0; i < STAGES; i++) begin
                stage[i].valid <= 1'b0;
            end
        end else begin
            stage[0].valid <= din.valid;
            for (int i = 1; i < STAGES; i++) begin
                stage[i].valid <= stage[i-1].valid;
            end
        end
    end

    // Payload chain
    always_ff @(posedge ap_clk) begin
        stage[0].payload <= din.payload;
        for (int i = 1; i < STAGES; i++) begin
            stage[i].payload <= stage[i-1].payload;
        end
    end

    assign dout = stage[STAGES-1];

    // Any stage still occupied
    always_comb begin
        busy = 1'b0;
        for (int i = 0; i < STAGES; i++) begin
            busy = busy | stage[i].valid;
        end
    end

endmodule : hyper_pipeline

// File: src/sync_fifo.sv
/*
 * Synchronous FIFO
 * Circular buffer with occupancy count, count-based prog_full,
 * registered read data with valid, and a busy window after reset
 */

`include "engine_params.svh"

module sync_fifo #(
    parameter int DEPTH       = 16,
    parameter int WIDTH       = 64,
    parameter int PROG_THRESH = 8
) (
    input  logic                       ap_clk,
    input  logic                       areset_template_engine,
    input  logic [WIDTH-1:0]           din,
    input  logic                       wr_en,
    input  logic                       rd_en,
    output logic [WIDTH-1:0]           dout,
    output fifo_state_pkg::fifo_state_t state
);

    localparam int ADDR_W     = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W      = $clog2(DEPTH + 1);
    localparam int RST_CYCLES = `ENGINE_FIFO_RESET_CYCLES;
    localparam int RST_W      = $clog2(RST_CYCLES + 1);

    logic [WIDTH-1:0]  mem [DEPTH];
    logic [ADDR_W-1:0] wr_ptr;
    logic [ADDR_W-1:0] rd_ptr;
    logic [CNT_W-1:0]  count;
    logic [RST_W-1:0]  rst_cnt;
    logic              rst_busy;
    logic              rd_valid;
    logic              wr_fire;
    logic              rd_fire;

    // Nothing moves while the queue is leaving reset
    assign rst_busy = (rst_cnt != '0);
    assign wr_fire  = wr_en & ~rst_busy;
    assign rd_fire  = rd_en & ~rst_busy;

    // ------------------------------
    // Reset-busy window
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_template_engine) begin
            rst_cnt <= RST_W'(RST_CYCLES);
        end else if (rst_busy) begin
            rst_cnt <= rst_cnt - 1'b1;
        end
    end

    // ------------------------------
    // Pointers and occupancy
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_template_engine) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_fire;
            if (wr_fire) begin
                wr_ptr <= (wr_ptr == ADDR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_fire) begin
                rd_ptr <= (rd_ptr == ADDR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_fire, rd_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // ------------------------------
    // Storage and read data
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (wr_fire) begin
            mem[wr_ptr] <= din;
        end
        if (rd_fire) begin
            dout <= mem[rd_ptr];
        end
    end

    // Flags follow the count register directly
    always_comb begin
        state.full      = (count == CNT_W'(DEPTH));
        state.empty     = (count == '0);
        state.valid     = rd_valid;
        state.prog_full = (count >= CNT_W'(PROG_THRESH));
        state.rst_busy  = rst_busy;
    end

endmodule : sync_fifo

// File: src/fifo_state_pkg.sv
/*
 * FIFO handshake and status types
 * Neighbour read enable, status reported to neighbours and
 * the raw flags a queue produces
 */

package fifo_state_pkg;

    // ------------------------------
    // From the neighbour
    // ------------------------------
    typedef struct packed {
        // Held high to allow pops
        logic rd_en;
    } fifo_ctrl_t;

    // ------------------------------
    // To the neighbour
    // ------------------------------
    typedef struct packed {
        logic empty;
        logic prog_full;
    } fifo_status_t;

    // ------------------------------
    // Produced by a queue
    // ------------------------------
    typedef struct packed {
        logic full;
        logic empty;
        // Read data valid, one cycle after a pop
        logic valid;
        logic prog_full;
        // Queue still leaving reset
        logic rst_busy;
    } fifo_state_t;

endpackage : fifo_state_pkg

// File: src/engine_packet_pkg.sv
/*
 * Engine packet types
 * Payload carried through the queues and the processing chain,
 * and the packet word with its valid flag
 */

`include "engine_params.svh"

package engine_packet_pkg;

    // ------------------------------
    // Payload, 64 bits
    // ------------------------------
    typedef struct packed {
        // Ordering tag set by the producer
        logic [`ENGINE_SEQ_WIDTH-1:0]    seq;
        // Target vertex
        logic [`ENGINE_VERTEX_WIDTH-1:0] vertex;
        logic [`ENGINE_DATA_WIDTH-1:0]   data;
    } engine_payload_t;

    // ------------------------------
    // Packet, 65 bits
    // ------------------------------
    typedef struct packed {
        logic            valid;
        engine_payload_t payload;
    } engine_packet_t;

endpackage : engine_packet_pkg

// File: include/engine_params.svh
/*
 * Engine pipeline parameters
 * Packet field widths, FIFO sizing, back-pressure threshold,
 * FIFO reset-busy length and processing depth
 */

`ifndef ENGINE_PARAMS_SVH
`define ENGINE_PARAMS_SVH

// ------------------------------
// Engine packet fields
// ------------------------------
`define ENGINE_SEQ_WIDTH         16
`define ENGINE_VERTEX_WIDTH      16
`define ENGINE_DATA_WIDTH        32

// ------------------------------
// Queues
// ------------------------------
`define ENGINE_FIFO_DEPTH        16
// Occupancy at which prog_full rises
`define ENGINE_PROG_THRESH       8
// Busy window after reset falls
`define ENGINE_FIFO_RESET_CYCLES 4

// ------------------------------
// Processing
// ------------------------------
`define ENGINE_PIPELINE_STAGES   2

`endif
